/* note_templates.mem */
// One 32-bit word per bin, nibble n holds the weight of note n
// Eight bins per row, bin 0 at the left of the first row
3000000F 3000000F 0000000F 0000000F 000000F3 000000F3 000000F0 000000F0
00000F30 00000F30 00000F00 00000F00 0000F300 0000F300 0000F000 0000F000
000F3000 000F3000 000F0000 000F0000 00F30000 00F30000 00F00000 00F00000
0F300000 0F300000 0F000000 0F000000 F3000000 F3000000 F0000000 F0000000

/* note_tests.txt */
# F: 32 hex magnitudes, bin 0 first    R: number of random frames
# A: note, high(1)/low(0), up(1)/down(0), pulses, expected high and low readout in hex
A 0 1 1 0 200 100
F 0 0 0 0 0 0 0 0 f f f f 3 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
F f f f f 0 0 0 0 f f f f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
F 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
F f f f f 0 0 0 0 f f f f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
F 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f f f f 3 3 0 0 0 0 0 0
A 0 1 0 3 1d0 100
F f f f f 0 0 0 0 f f f f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
A 5 0 1 70 200 3ff
A 5 0 0 70 200 000
A 3 1 1 40 3ff 100
F 0 0 0 0 0 0 0 0 0 0 0 0 f f f f 3 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0
A 2 0 1 2 200 120
R 30
F 3 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f f f f

/* all.f */
guitar_pkg.sv
spectrum_if.sv
spectrum_correlator.sv
correlation_normalizer.sv
note_hysteresis.sv
note_serializer.sv
note_detector_top.sv
tb_note_detector.sv

/* tb_note_detector.sv */
`timescale 1ns/10ps

module tb_note_detector import guitar_pkg::*; ();

    logic       clk_65mhz;
    logic       arst_n;
    logic       mag_valid;
    logic       mag_ready;
    mag_t       mag_data;
    logic       mag_last;
    note_idx_t  adj_note;
    logic       adj_high;
    logic       adj_up;
    logic       adj_down;
    corr_t      thresh_high_view;
    corr_t      thresh_low_view;
    logic       note_sync;
    logic       note_data;

    logic [31:0] tmpl [NUM_BINS];                // Reference spectra as the DUT sees them
    int          thr_hi [NUM_NOTES];             // Model thresholds
    int          thr_lo [NUM_NOTES];
    note_mask_t  model_mask;                     // Model note state
    note_mask_t  exp_q [$];                      // Words still owed on the serial link
    mag_t        frame [NUM_BINS];               // Frame being sent
    logic [31:0] rng;
    note_mask_t  rx_word;
    int          rx_cnt;                         // Bits received of the current word

    note_detector_top dut0 (.*);

    always #2 clk_65mhz = ~clk_65mhz;            // 4 ns period

    ////////////////////////////////////////////////////////////
    // Checks and helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_notes(note_mask_t exp, note_mask_t got);
        if (got !== exp)
            abort_run($sformatf("ERROR note_data word: expected 0x%h got 0x%h", exp, got));
    endtask

    task automatic check_thresh(string name, corr_t exp, corr_t got);
        if (got !== exp)
            abort_run($sformatf("ERROR %s: expected 0x%h got 0x%h", name, exp, got));
    endtask

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // One adjust step clamped to 0 and 1023
    function automatic int step_level(int level, logic up);
        int moved;
        moved = up ? level + THRESH_STEP : level - THRESH_STEP;
        if (moved > 1023)
            moved = 1023;
        else if (moved < 0)
            moved = 0;
        return moved;
    endfunction

    // Dot, energy, divide and hysteresis for the frame just sent
    function automatic note_mask_t predict_frame();
        longint dot;
        longint energy;
        int     corr;
        energy = 0;
        for (int b = 0; b < NUM_BINS; b++)
            energy += longint'(frame[b]);
        for (int n = 0; n < NUM_NOTES; n++) begin
            dot = 0;
            for (int b = 0; b < NUM_BINS; b++)
                dot += longint'(frame[b]) * longint'(tmpl[b][4*n +: 4]);
            corr = (energy == 0) ? 0 : int'((dot << CORR_SHIFT) / energy);
            if (corr >= thr_hi[n])
                model_mask[n] = 1'b1;
            else if (corr < thr_lo[n])
                model_mask[n] = 1'b0;                // Between the levels keeps the state
        end
        return model_mask;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic send_bin(mag_t mag, logic last, int gap);
        int   waited;
        logic taken;
        if (gap > 0)
            mag_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk_65mhz);
            #1;
        end
        mag_valid = 1'b1;
        mag_data  = mag;
        mag_last  = last;
        waited    = 0;
        taken     = 1'b0;
        while (!taken && waited < 400) begin
            taken = mag_ready;                       // Transfer happens at the coming edge
            @(posedge clk_65mhz);
            #1;
            waited++;
        end
        if (!taken)
            abort_run("mag_ready stayed low for 400 cycles");
        mag_last = 1'b0;
    endtask

    task automatic send_frame(logic gapped);
        for (int b = 0; b < NUM_BINS; b++)
            send_bin(frame[b], b == NUM_BINS - 1, gapped ? 1 + int'(xorshift32() % 3) : 0);
        mag_valid = 1'b0;
        exp_q.push_back(predict_frame());
    endtask

    // Low noise floor plus strong energy in one or two note bands
    task automatic random_frame();
        int          g1;
        int          g2;
        logic [31:0] r;
        g1 = int'(xorshift32() % NUM_NOTES);
        g2 = int'(xorshift32() % NUM_NOTES);
        for (int b = 0; b < NUM_BINS; b++) begin
            r        = xorshift32();
            frame[b] = mag_t'(r[7:0]);
            if (b / 4 == g1 || b / 4 == g2)
                frame[b] = frame[b] + mag_t'(r[19:8]);
        end
    endtask

    // Wait until every frame sent so far came out on the serial link
    task automatic drain_words();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 2000) begin
            @(posedge clk_65mhz);
            #1;
            waited++;
        end
        if (exp_q.size() != 0)
            abort_run("serial words still missing after 2000 cycles");
    endtask

    task automatic adjust(int note, logic high, logic up, int count, corr_t exp_hi,
                          corr_t exp_lo);
        adj_note = note_idx_t'(note);
        adj_high = high;
        repeat (count) begin
            adj_up   = up;                           // One pulse per cycle
            adj_down = !up;
            @(posedge clk_65mhz);
            #1;
            if (high)
                thr_hi[note] = step_level(thr_hi[note], up);
            else
                thr_lo[note] = step_level(thr_lo[note], up);
        end
        adj_up   = 1'b0;
        adj_down = 1'b0;
        check_thresh("thresh_high_view", exp_hi, thresh_high_view);
        check_thresh("thresh_low_view", exp_lo, thresh_low_view);
    endtask

    // Serial receiver sampled mid-cycle with bit 0 beside sync
    always @(negedge clk_65mhz) begin
        if (arst_n && rx_cnt == 0) begin
            if (note_sync) begin
                rx_word[0] = note_data;
                rx_cnt     = 1;
            end
        end else if (arst_n) begin
            if (note_sync) begin
                abort_run("note_sync went high again inside a serial word");
            end else begin
                rx_word[rx_cnt] = note_data;
                rx_cnt++;
                if (rx_cnt == NUM_NOTES) begin
                    rx_cnt = 0;
                    if (exp_q.size() == 0)
                        abort_run("a serial word arrived with no frame outstanding");
                    else
                        check_notes(exp_q.pop_front(), rx_word);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Command loop
    ////////////////////////////////////////////////////////////

    initial begin
        int               fd;
        int               cmd;
        int               count;
        int               note;
        int               high;
        int               up;
        int               exp_hi;
        int               exp_lo;
        int               value;
        logic [8*128-1:0] skip;
        clk_65mhz  = 1'b0;
        arst_n     = 1'b0;
        mag_valid  = 1'b0;
        mag_data   = '0;
        mag_last   = 1'b0;
        adj_note   = '0;
        adj_high   = 1'b0;
        adj_up     = 1'b0;
        adj_down   = 1'b0;
        rng        = 32'd65874;
        rx_cnt     = 0;
        model_mask = '0;
        for (int n = 0; n < NUM_NOTES; n++) begin
            thr_hi[n] = THRESH_HIGH_INIT;
            thr_lo[n] = THRESH_LOW_INIT;
        end
        $readmemh(TEMPLATE_FILE, tmpl);
        fd = $fopen("note_tests.txt", "r");
        if (fd == 0)
            abort_run("could not open note_tests.txt");
        repeat (10) @(posedge clk_65mhz);
        #1;
        arst_n = 1'b1;
        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": value = $fgets(skip, fd);       // Comment row
                "F": begin
                    for (int b = 0; b < NUM_BINS; b++)
                        value = $fscanf(fd, " %h", frame[b]);
                    send_frame(1'b0);                // Frames back to back with no gaps
                end
                "R": begin
                    value = $fscanf(fd, " %d", count);
                    repeat (count) begin
                        random_frame();
                        send_frame(1'b1);
                    end
                end
                "A": begin
                    value = $fscanf(fd, " %d %d %d %d %h %h", note, high, up, count,
                                    exp_hi, exp_lo);
                    drain_words();                   // Frames in flight use the old levels
                    adjust(note, high[0], up[0], count, corr_t'(exp_hi), corr_t'(exp_lo));
                end
                default: abort_run("unknown command in note_tests.txt");
            endcase
        end
        $fclose(fd);
        drain_words();
        repeat (20) @(posedge clk_65mhz);            // Catch any extra word
        $display("Regression passed");
        $finish;
    end

endmodule

/* note_detector_top.sv */
`timescale 1ns/10ps

module note_detector_top import guitar_pkg::*; (
    input  logic      clk_65mhz,
    input  logic      arst_n,
    // Magnitude stream
    input  logic      mag_valid,
    output logic      mag_ready,
    input  mag_t      mag_data,
    input  logic      mag_last,
    // Threshold adjust and readout
    input  note_idx_t adj_note,
    input  logic      adj_high,
    input  logic      adj_up,
    input  logic      adj_down,
    output corr_t     thresh_high_view,
    output corr_t     thresh_low_view,
    // Serial note link
    output logic      note_sync,
    output logic      note_data
);

    corr_if     corr_link ();                    // Stage 1 to stage 2
    norm_if     norm_link ();                    // Stage 2 to stage 3

    logic       notes_update;
    note_mask_t notes_active;

    ////////////////////////////////////////////////////////////
    // Four stage pipeline
    ////////////////////////////////////////////////////////////

    spectrum_correlator correlator0 (
        .clk_65mhz (clk_65mhz),
        .arst_n    (arst_n),
        .mag_valid (mag_valid),
        .mag_ready (mag_ready),
        .mag_data  (mag_data),
        .mag_last  (mag_last),
        .corr_out  (corr_link.source)
    );

    correlation_normalizer normalizer0 (
        .clk_65mhz (clk_65mhz),
        .arst_n    (arst_n),
        .corr_in   (corr_link.sink),
        .norm_out  (norm_link.source)
    );

    note_hysteresis hysteresis0 (
        .clk_65mhz        (clk_65mhz),
        .arst_n           (arst_n),
        .norm_in          (norm_link.sink),
        .adj_note         (adj_note),
        .adj_high         (adj_high),
        .adj_up           (adj_up),
        .adj_down         (adj_down),
        .thresh_high_view (thresh_high_view),
        .thresh_low_view  (thresh_low_view),
        .update           (notes_update),
        .notes            (notes_active)
    );

    note_serializer serializer0 (
        .clk_65mhz (clk_65mhz),
        .arst_n    (arst_n),
        .update    (notes_update),
        .notes     (notes_active),
        .note_sync (note_sync),
        .note_data (note_data)
    );

endmodule

/* note_serializer.sv */
`timescale 1ns/10ps

module note_serializer import guitar_pkg::*; (
    input  logic       clk_65mhz,
    input  logic       arst_n,
    input  logic       update,
    input  note_mask_t notes,
    output logic       note_sync,
    output logic       note_data
);

    ser_state_t state;
    note_mask_t shreg;                           // Bits still to send, LSB first
    note_idx_t  bit_cnt;                         // Bits left after the sync cycle
    note_mask_t pending;                         // Newest word that arrived mid-shift
    logic       pend_valid;
    logic       word_done;
    logic       start;
    note_mask_t start_word;
    logic       take_pend;

    assign word_done = (state == ser_shift) && (bit_cnt == '0);

    // Start a word from idle, or right after the last bit when one is queued
    always_comb begin
        start      = 1'b0;
        start_word = notes;
        if (state == ser_idle) begin
            start = update;
        end else if (word_done) begin
            start = pend_valid | update;
            if (pend_valid)
                start_word = pending;            // Older word goes first
        end
    end

    // Keep an update unless it starts immediately
    assign take_pend = update && (state == ser_shift) && !(word_done && !pend_valid);

    always_ff @(posedge clk_65mhz or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ser_idle;
            bit_cnt    <= '0;
            note_sync  <= 1'b0;
            note_data  <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            note_sync <= start;                  // Sync marks bit 0 only
            if (start) begin
                state     <= ser_shift;
                note_data <= start_word[0];
                bit_cnt   <= note_idx_t'(NUM_NOTES - 1);
            end else if (word_done) begin
                state     <= ser_idle;
                note_data <= 1'b0;
            end else if (state == ser_shift) begin
                note_data <= shreg[0];
                bit_cnt   <= bit_cnt - 1'b1;
            end

            if (take_pend)
                pend_valid <= 1'b1;
            else if (word_done && pend_valid)
                pend_valid <= 1'b0;              // Queued word now sending
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (start)
            shreg <= start_word >> 1;
        else
            shreg <= shreg >> 1;
        if (take_pend)
            pending <= notes;                    // Later update overwrites older one
    end

endmodule

/* note_hysteresis.sv */
`timescale 1ns/10ps

module note_hysteresis import guitar_pkg::*; (
    input  logic       clk_65mhz,
    input  logic       arst_n,
    norm_if.sink       norm_in,
    input  note_idx_t  adj_note,
    input  logic       adj_high,
    input  logic       adj_up,
    input  logic       adj_down,
    output corr_t      thresh_high_view,
    output corr_t      thresh_low_view,
    output logic       update,
    output note_mask_t notes
);

    corr_t thresh_high [NUM_NOTES];              // Turn-on level per note
    corr_t thresh_low  [NUM_NOTES];              // Turn-off level per note

    // Move a threshold one step, clamped to the corr range
    function automatic corr_t step_thresh(corr_t thr, logic up);
        corr_t step;
        corr_t max_thr;
        step    = corr_t'(THRESH_STEP);
        max_thr = '1;
        if (up)
            return (thr > max_thr - step) ? max_thr : thr + step;
        return (thr < step) ? '0 : thr - step;
    endfunction

    ////////////////////////////////////////////////////////////
    // Thresholds and note state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < NUM_NOTES; n++) begin
                thresh_high[n] <= THRESH_HIGH_INIT;
                thresh_low[n]  <= THRESH_LOW_INIT;
            end
            notes  <= '0;
            update <= 1'b0;
        end else begin
            // Both pulses together cancel out
            if (adj_up ^ adj_down) begin
                if (adj_high)
                    thresh_high[adj_note] <= step_thresh(thresh_high[adj_note], adj_up);
                else
                    thresh_low[adj_note]  <= step_thresh(thresh_low[adj_note], adj_up);
            end

            if (norm_in.valid) begin
                if (norm_in.corr >= thresh_high[norm_in.note])
                    notes[norm_in.note] <= 1'b1;
                else if (norm_in.corr < thresh_low[norm_in.note])
                    notes[norm_in.note] <= 1'b0;
                // In between keeps the previous state
            end

            update <= norm_in.valid & norm_in.last;  // Whole frame applied
        end
    end

    // Readout of the selected note for the display ports
    assign thresh_high_view = thresh_high[adj_note];
    assign thresh_low_view  = thresh_low[adj_note];

endmodule

/* correlation_normalizer.sv */
`timescale 1ns/10ps

module correlation_normalizer import guitar_pkg::*; (
    input  logic   clk_65mhz,
    input  logic   arst_n,
    corr_if.sink   corr_in,
    norm_if.source norm_out
);

    div_state_t state;
    note_idx_t  note;                            // Note being divided
    logic [3:0] iter;                            // Quotient bit from 10 down to 0
    dot_vec_t   dots_q;
    energy_t    energy_q;
    logic [$bits(dot_t)+CORR_SHIFT-1:0] rem;     // Partial remainder
    logic [$bits(dot_t)+CORR_SHIFT-1:0] divisor; // Energy shifted to current bit
    corr_t      quo;
    logic       rem_ge;

    assign rem_ge = rem >= divisor;              // Restoring step decision

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz or negedge arst_n) begin
        if (!arst_n) begin
            state <= div_idle;
            note  <= '0;
            iter  <= '0;
        end else begin
            case (state)
                div_idle: if (corr_in.valid) begin
                    state <= div_divide;
                    note  <= '0;
                    iter  <= 4'($bits(corr_t));  // 11 iterations per note
                end
                div_divide: begin
                    iter <= iter - 1'b1;
                    if (iter == '0)
                        state <= div_emit;       // Last quotient bit done
                end
                default: if (norm_out.last) begin
                    state <= div_idle;
                end else begin
                    state <= div_divide;
                    note  <= note + 1'b1;
                    iter  <= 4'($bits(corr_t));
                end
            endcase
        end
    end

    // Shift-subtract datapath
    always_ff @(posedge clk_65mhz) begin
        case (state)
            div_idle: if (corr_in.valid) begin
                dots_q   <= corr_in.dots;
                energy_q <= corr_in.energy;
                rem      <= {corr_in.dots[0], {CORR_SHIFT{1'b0}}};
                divisor  <= {corr_in.energy, {$bits(corr_t){1'b0}}};
            end
            div_divide: begin
                if (rem_ge)
                    rem <= rem - divisor;
                quo     <= {quo[$bits(corr_t)-2:0], rem_ge};
                divisor <= divisor >> 1;
            end
            default: begin                       // Preload the next note
                rem     <= {dots_q[note + 1'b1], {CORR_SHIFT{1'b0}}};
                divisor <= {energy_q, {$bits(corr_t){1'b0}}};
            end
        endcase
    end

    assign corr_in.ready  = (state == div_idle);
    assign norm_out.valid = (state == div_emit);
    assign norm_out.note  = note;
    assign norm_out.last  = (note == note_idx_t'(NUM_NOTES - 1));
    assign norm_out.corr  = (energy_q == '0) ? '0 : quo;  // Silent frame gives no match

endmodule

/* spectrum_correlator.sv */
`timescale 1ns/10ps

module spectrum_correlator import guitar_pkg::*; (
    input  logic    clk_65mhz,
    input  logic    arst_n,
    input  logic    mag_valid,
    output logic    mag_ready,
    input  mag_t    mag_data,
    input  logic    mag_last,
    corr_if.source  corr_out
);

    template_word_t template_rom [NUM_BINS];     // Reference spectra, all notes per bin

    bin_idx_t       bin_idx;                     // Bin of the next accepted magnitude
    template_word_t weights;
    dot_vec_t       dot_acc;
    dot_vec_t       dot_next;
    energy_t        energy_acc;
    energy_t        energy_next;
    dot_vec_t       dots_q;                      // Held frame result
    energy_t        energy_q;
    logic           out_valid;
    logic           mag_take;

    initial begin
        $readmemh(TEMPLATE_FILE, template_rom);
    end

    // Stall input only while a finished frame waits for the normalizer
    assign mag_ready = ~out_valid | corr_out.ready;
    assign mag_take  = mag_valid & mag_ready;
    assign weights   = template_rom[bin_idx];

    ////////////////////////////////////////////////////////////
    // Multiply-accumulate, all notes in parallel
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int n = 0; n < NUM_NOTES; n++) begin
            dot_next[n] = dot_acc[n] + dot_t'(mag_data) * dot_t'(weights[n]);
        end
        energy_next = energy_acc + energy_t'(mag_data);
    end

    always_ff @(posedge clk_65mhz or negedge arst_n) begin
        if (!arst_n) begin
            bin_idx    <= '0;
            dot_acc    <= '0;
            energy_acc <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (out_valid && corr_out.ready)
                out_valid <= 1'b0;               // Normalizer took the frame
            if (mag_take) begin
                if (mag_last) begin
                    bin_idx    <= '0;            // Next frame starts straight away
                    dot_acc    <= '0;
                    energy_acc <= '0;
                    out_valid  <= 1'b1;
                end else begin
                    bin_idx    <= bin_idx + 1'b1;
                    dot_acc    <= dot_next;
                    energy_acc <= energy_next;
                end
            end
        end
    end

    // Result register, loaded with the sums including the last bin
    always_ff @(posedge clk_65mhz) begin
        if (mag_take && mag_last) begin
            dots_q   <= dot_next;
            energy_q <= energy_next;
        end
    end

    assign corr_out.valid  = out_valid;
    assign corr_out.dots   = dots_q;
    assign corr_out.energy = energy_q;

endmodule

/* spectrum_if.sv */
`timescale 1ns/10ps

// Correlator to normalizer, one beat per frame with valid/ready
interface corr_if import guitar_pkg::*; ();

    logic     valid;                             // Frame sums ready
    logic     ready;                             // Normalizer idle
    dot_vec_t dots;                              // Per note dot products
    energy_t  energy;                            // Frame magnitude sum

    modport source (
        output valid, dots, energy,
        input  ready
    );

    modport sink (
        input  valid, dots, energy,
        output ready
    );

endinterface

// Normalizer to hysteresis, one beat per note and no back-pressure
interface norm_if import guitar_pkg::*; ();

    logic      valid;
    note_idx_t note;                             // Which note this beat is for
    corr_t     corr;
    logic      last;                             // Final note of the frame

    modport source (
        output valid, note, corr, last
    );

    modport sink (
        input  valid, note, corr, last
    );

endinterface

/* guitar_pkg.sv */
package guitar_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int NUM_NOTES  = 8;               // Notes detected per frame
    localparam int NUM_BINS   = 32;              // Magnitude bins per frame
    localparam int CORR_SHIFT = 6;               // Dot product scale before divide

    localparam string TEMPLATE_FILE = "note_templates.mem";

    ////////////////////////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] mag_t;                  // One FFT magnitude bin
    typedef logic [3:0]  weight_t;               // One template weight
    typedef weight_t [NUM_NOTES-1:0] template_word_t;  // Note 0 sits in bits 3:0

    typedef logic [$clog2(NUM_BINS)-1:0]  bin_idx_t;
    typedef logic [$clog2(NUM_NOTES)-1:0] note_idx_t;

    // 32 bins of 16 bit magnitude times 4 bit weight
    typedef logic [24:0] dot_t;
    typedef dot_t [NUM_NOTES-1:0] dot_vec_t;
    typedef logic [20:0] energy_t;               // Sum of 32 magnitudes

    typedef logic [9:0]           corr_t;        // Normalized correlation, also thresholds
    typedef logic [NUM_NOTES-1:0] note_mask_t;   // One bit per note

    // Threshold defaults and adjust step, in corr units
    localparam corr_t THRESH_HIGH_INIT = 10'h200;
    localparam corr_t THRESH_LOW_INIT  = 10'h100;
    localparam int    THRESH_STEP      = 16;

    ////////////////////////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        div_idle,                                // Waiting for a frame
        div_divide,                              // One quotient bit per cycle
        div_emit                                 // Present one note result
    } div_state_t;

    typedef enum logic {
        ser_idle,
        ser_shift
    } ser_state_t;

endpackage
